//--- dcache.f
src/dcache_pkg.sv
src/dcache_way.sv
src/dcache_way_select.sv
src/dcache_data_ram.sv
src/dcache_miss_fsm.sv
src/dcache_req_ctrl.sv
src/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- src/dcache.sv
`timescale 1ns/100ps

module dcache (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              req,
    input  logic [31:0]                       addr,
    input  logic                              is_write,
    input  logic [dcache_pkg::DATA_BYTES-1:0] write_en,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] wdata,
    input  dcache_pkg::cache_op_e             cop,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [dcache_pkg::DATA_WIDTH-1:0] rdata,
    output logic                              mem_valid,
    output logic                              mem_is_write,
    output logic [31:0]                       mem_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_wdata,
    input  logic                              mem_okay,
    input  logic                              mem_last,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_rdata
);
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0]               way_hit;
    logic [NUM_WAYS-1:0]               way_valid;
    logic [NUM_WAYS-1:0]               way_dirty;
    logic [NUM_WAYS-1:0][TAG_BITS-1:0] way_tag;
    way_cmd_e                          way_cmd;
    logic [WAY_BITS-1:0]               cmd_way;
    logic [INDEX_BITS-1:0]             cmd_index;
    logic [TAG_BITS-1:0]               cmd_tag;
    logic                              hit;
    logic [WAY_BITS-1:0]               hit_way;
    logic [WAY_BITS-1:0]               victim_way;
    logic                              victim_dirty;
    logic [TAG_BITS-1:0]               victim_tag;
    logic                              plru_touch;
    logic [WAY_BITS-1:0]               touch_way;
    logic                              start_refill;
    logic                              start_flush;
    logic                              miss_avail;
    logic                              req_word_ready;
    logic                              ram1_en;
    logic [DATA_BYTES-1:0]             ram1_write_en;
    logic [RAM_ADDR_BITS-1:0]          ram1_addr;
    logic [DATA_WIDTH-1:0]             ram1_wdata;
    logic                              ram2_write_en;
    logic [RAM_ADDR_BITS-1:0]          ram2_addr;
    logic [DATA_WIDTH-1:0]             ram2_wdata;
    logic [DATA_WIDTH-1:0]             ram2_rdata;

    dcache_req_ctrl req_ctrl_inst (
        .clk(clk), .resetn(resetn), .req(req), .addr(addr), .is_write(is_write),
        .write_en(write_en), .wdata(wdata), .cop(cop), .addr_ok(addr_ok), .data_ok(data_ok),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way), .miss_avail(miss_avail),
        .req_word_ready(req_word_ready), .way_cmd(way_cmd), .cmd_way(cmd_way),
        .cmd_index(cmd_index), .cmd_tag(cmd_tag), .plru_touch(plru_touch),
        .touch_way(touch_way), .start_refill(start_refill), .start_flush(start_flush),
        .ram_en(ram1_en), .ram_write_en(ram1_write_en), .ram_addr(ram1_addr),
        .ram_wdata(ram1_wdata)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        dcache_way #(.WAY_ID(i)) way_inst (
            .clk(clk), .resetn(resetn), .addr(addr), .way_cmd(way_cmd), .cmd_way(cmd_way),
            .cmd_index(cmd_index), .cmd_tag(cmd_tag), .hit(way_hit[i]),
            .valid(way_valid[i]), .dirty(way_dirty[i]), .tag(way_tag[i])
        );
    end

    dcache_way_select way_select_inst (
        .clk(clk), .resetn(resetn), .index(addr[INDEX_LSB +: INDEX_BITS]),
        .hit_bits(way_hit), .valid_bits(way_valid), .dirty_bits(way_dirty),
        .tag_bits(way_tag), .plru_touch(plru_touch), .touch_way(touch_way), .hit(hit),
        .hit_way(hit_way), .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    // a flush writes back the indexed way, not the replacement victim
    dcache_miss_fsm miss_inst (
        .clk(clk), .resetn(resetn), .start_refill(start_refill), .start_flush(start_flush),
        .line_addr(addr), .victim_way(victim_way),
        .victim_dirty(start_flush ? way_dirty[cmd_way] : victim_dirty),
        .victim_tag(start_flush ? way_tag[cmd_way] : victim_tag),
        .flush_way(cmd_way), .req_addr(addr), .miss_avail(miss_avail),
        .req_word_ready(req_word_ready), .ram_write_en(ram2_write_en),
        .ram_addr(ram2_addr), .ram_wdata(ram2_wdata), .ram_rdata(ram2_rdata),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_okay(mem_okay), .mem_last(mem_last),
        .mem_rdata(mem_rdata)
    );

    dcache_data_ram data_ram_inst (
        .clk(clk), .en_1(ram1_en), .write_en_1(ram1_write_en), .addr_1(ram1_addr),
        .wdata_1(ram1_wdata), .rdata_1(rdata), .write_en_2(ram2_write_en),
        .addr_2(ram2_addr), .wdata_2(ram2_wdata), .rdata_2(ram2_rdata)
    );

endmodule

//--- src/dcache_data_ram.sv
`timescale 1ns/100ps

module dcache_data_ram (
    input  logic                                 clk,
    input  logic                                 en_1,
    input  logic [dcache_pkg::DATA_BYTES-1:0]    write_en_1,
    input  logic [dcache_pkg::RAM_ADDR_BITS-1:0] addr_1,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    wdata_1,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    rdata_1,
    input  logic                                 write_en_2,
    input  logic [dcache_pkg::RAM_ADDR_BITS-1:0] addr_2,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    wdata_2,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    rdata_2
);
    import dcache_pkg::*;

    logic [DATA_WIDTH-1:0] mem [2**RAM_ADDR_BITS];

    // read-first on both ports, port 2 always enabled
    always_ff @(posedge clk) begin
        rdata_2 <= mem[addr_2];
        if (en_1) begin
            rdata_1 <= mem[addr_1];
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (write_en_1[b]) begin
                    mem[addr_1][8*b +: 8] <= wdata_1[8*b +: 8];
                end
            end
        end
        if (write_en_2) begin
            mem[addr_2] <= wdata_2;
        end
    end

endmodule

//--- src/dcache_miss_fsm.sv
`timescale 1ns/100ps

module dcache_miss_fsm (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 start_refill,
    input  logic                                 start_flush,
    input  logic [31:0]                          line_addr,
    input  logic [dcache_pkg::WAY_BITS-1:0]      victim_way,
    input  logic                                 victim_dirty,
    input  logic [dcache_pkg::TAG_BITS-1:0]      victim_tag,
    input  logic [dcache_pkg::WAY_BITS-1:0]      flush_way,
    input  logic [31:0]                          req_addr,
    output logic                                 miss_avail,
    output logic                                 req_word_ready,
    output logic                                 ram_write_en,
    output logic [dcache_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    ram_wdata,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    ram_rdata,
    output logic                                 mem_valid,
    output logic                                 mem_is_write,
    output logic [31:0]                          mem_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    mem_wdata,
    input  logic                                 mem_okay,
    input  logic                                 mem_last,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    mem_rdata
);
    import dcache_pkg::*;

    miss_state_e            state;
    logic [31:0]            line_q;
    logic [WAY_BITS-1:0]    way_q;
    logic [OFFSET_BITS-1:0] pos_q;
    logic [NUM_WORDS-1:0]   ready_q;
    logic                   vdirty_q;
    logic [TAG_BITS-1:0]    vtag_q;
    // buffer writes trail the RAM access by one cycle
    logic                   vwrite_q;
    logic [OFFSET_BITS-1:0] voffset_q;
    logic [DATA_WIDTH-1:0]  victim_buf [NUM_WORDS];
    logic                   done;
    logic                   in_line;

    assign done       = mem_okay && mem_last;
    assign miss_avail = state == IDLE || (state == WRITE && done);

    assign in_line        = state == READ && req_addr[31:INDEX_LSB] == line_q[31:INDEX_LSB];
    assign req_word_ready = !in_line || ready_q[req_addr[OFFSET_LSB +: OFFSET_BITS]];

    assign ram_write_en = state == READ && mem_okay;
    assign ram_addr     = {way_q, line_q[INDEX_LSB +: INDEX_BITS], pos_q};
    assign ram_wdata    = mem_rdata;

    assign mem_valid    = state == READ || state == WRITE || state == FLUSH;
    assign mem_is_write = state == WRITE || state == FLUSH;
    assign mem_addr     = line_q;
    // last victim word may still be landing in the buffer
    assign mem_wdata = (vwrite_q && voffset_q == pos_q) ? ram_rdata : victim_buf[pos_q];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= IDLE;
            ready_q  <= '0;
            vwrite_q <= 1'b0;
        end else begin
            vwrite_q  <= ram_write_en || state == FILL;
            voffset_q <= pos_q;
            case (state)
                READ: begin
                    if (mem_okay) begin
                        pos_q          <= pos_q + OFFSET_BITS'(1);
                        ready_q[pos_q] <= 1'b1;
                    end
                    if (done) begin
                        state <= vdirty_q ? WRITE : IDLE;
                        // victim goes back to its own line, word zero first
                        line_q[31:TAG_LSB]    <= vtag_q;
                        line_q[INDEX_LSB-1:0] <= '0;
                        pos_q                 <= '0;
                    end
                end
                WRITE, FLUSH: begin
                    if (mem_okay) begin
                        pos_q <= pos_q + OFFSET_BITS'(1);
                    end
                    if (done) begin
                        state <= IDLE;
                    end
                end
                FILL: begin
                    pos_q <= pos_q + OFFSET_BITS'(1);
                    if (pos_q == '1) begin
                        state <= FLUSH;
                    end
                end
                default: ;
            endcase

            if (start_refill) begin
                state    <= READ;
                line_q   <= {line_addr[31:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
                way_q    <= victim_way;
                pos_q    <= line_addr[OFFSET_LSB +: OFFSET_BITS];
                ready_q  <= '0;
                vdirty_q <= victim_dirty;
                vtag_q   <= victim_tag;
            end else if (start_flush && victim_dirty) begin
                // clean lines need no write-back
                state  <= FILL;
                line_q <= {victim_tag, line_addr[INDEX_LSB +: INDEX_BITS], {INDEX_LSB{1'b0}}};
                way_q  <= flush_way;
                pos_q  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vwrite_q) begin
            victim_buf[voffset_q] <= ram_rdata;
        end
    end

    a_valid_until_last: assert property (@(posedge clk) disable iff (resetn)
        $fell(mem_valid) |-> $past(done));

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

    // geometry
    localparam int DATA_WIDTH    = 32;
    localparam int DATA_BYTES    = 4;
    localparam int ALIGN_BITS    = 2;
    localparam int OFFSET_BITS   = 2;
    localparam int INDEX_BITS    = 2;
    localparam int WAY_BITS      = 2;
    localparam int NUM_WAYS      = 4;
    localparam int NUM_SETS      = 4;
    localparam int NUM_WORDS     = 4;
    localparam int TAG_BITS      = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int RAM_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    // field positions inside a byte address
    localparam int OFFSET_LSB = ALIGN_BITS;
    localparam int INDEX_LSB  = ALIGN_BITS + OFFSET_BITS;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_BITS;

    typedef enum logic [1:0] {
        COP_NONE,
        COP_INV_HIT,
        COP_WB_INV_INDEX
    } cache_op_e;

    // WAY_CLEAR drops the line, WAY_CLEAR_DIRTY only cleans it
    typedef enum logic [2:0] {
        WAY_KEEP,
        WAY_SET_DIRTY,
        WAY_ALLOC,
        WAY_CLEAR,
        WAY_CLEAR_DIRTY
    } way_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WRITE,
        FILL,
        FLUSH
    } miss_state_e;

endpackage

//--- src/dcache_req_ctrl.sv
`timescale 1ns/100ps

module dcache_req_ctrl (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 req,
    input  logic [31:0]                          addr,
    input  logic                                 is_write,
    input  logic [dcache_pkg::DATA_BYTES-1:0]    write_en,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    wdata,
    input  dcache_pkg::cache_op_e                cop,
    output logic                                 addr_ok,
    output logic                                 data_ok,
    input  logic                                 hit,
    input  logic [dcache_pkg::WAY_BITS-1:0]      hit_way,
    input  logic [dcache_pkg::WAY_BITS-1:0]      victim_way,
    input  logic                                 miss_avail,
    input  logic                                 req_word_ready,
    output dcache_pkg::way_cmd_e                 way_cmd,
    output logic [dcache_pkg::WAY_BITS-1:0]      cmd_way,
    output logic [dcache_pkg::INDEX_BITS-1:0]    cmd_index,
    output logic [dcache_pkg::TAG_BITS-1:0]      cmd_tag,
    output logic                                 plru_touch,
    output logic [dcache_pkg::WAY_BITS-1:0]      touch_way,
    output logic                                 start_refill,
    output logic                                 start_flush,
    output logic                                 ram_en,
    output logic [dcache_pkg::DATA_BYTES-1:0]    ram_write_en,
    output logic [dcache_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    ram_wdata
);
    import dcache_pkg::*;

    logic                is_op;
    logic                to_hit;
    logic                to_op;
    logic                to_miss;
    logic [WAY_BITS-1:0] index_way;

    assign is_op     = cop != COP_NONE;
    assign index_way = addr[TAG_LSB +: WAY_BITS];

    // a hit in a refilling line waits for its word
    assign to_hit  = !is_op && hit && req_word_ready;
    assign to_op   = is_op && miss_avail;
    assign to_miss = req && !is_op && !hit && miss_avail;
    assign addr_ok = to_hit || to_op;

    assign cmd_index = addr[INDEX_LSB +: INDEX_BITS];
    assign cmd_tag   = addr[TAG_LSB +: TAG_BITS];

    always_comb begin
        way_cmd = WAY_KEEP;
        cmd_way = hit_way;
        if (to_miss) begin
            way_cmd = WAY_ALLOC;
            cmd_way = victim_way;
        end else if (req && to_hit && is_write) begin
            way_cmd = WAY_SET_DIRTY;
        end else if (req && to_op && cop == COP_INV_HIT && hit) begin
            way_cmd = WAY_CLEAR;
        end else if (req && to_op && cop == COP_WB_INV_INDEX) begin
            way_cmd = WAY_CLEAR;
            cmd_way = index_way;
        end
    end

    // a fresh allocation counts as a use
    assign plru_touch = req && (to_hit || to_miss);
    assign touch_way  = hit ? hit_way : victim_way;

    assign start_refill = to_miss;
    assign start_flush  = req && to_op && cop == COP_WB_INV_INDEX;

    assign ram_en       = req && to_hit;
    assign ram_write_en = is_write ? write_en : '0;
    assign ram_addr     = {hit_way, cmd_index, addr[OFFSET_LSB +: OFFSET_BITS]};
    assign ram_wdata    = wdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= req && addr_ok;
        end
    end

endmodule

//--- src/dcache_way.sv
`timescale 1ns/100ps

module dcache_way #(
    parameter int WAY_ID = 0
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic [31:0]                       addr,
    input  dcache_pkg::way_cmd_e              way_cmd,
    input  logic [dcache_pkg::WAY_BITS-1:0]   cmd_way,
    input  logic [dcache_pkg::INDEX_BITS-1:0] cmd_index,
    input  logic [dcache_pkg::TAG_BITS-1:0]   cmd_tag,
    output logic                              hit,
    output logic                              valid,
    output logic                              dirty,
    output logic [dcache_pkg::TAG_BITS-1:0]   tag
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0]   valid_q;
    logic [NUM_SETS-1:0]   dirty_q;
    logic [TAG_BITS-1:0]   tag_q [NUM_SETS];
    logic [INDEX_BITS-1:0] index;
    logic                  selected;

    assign index    = addr[INDEX_LSB +: INDEX_BITS];
    assign selected = cmd_way == WAY_BITS'(WAY_ID);

    // lookup on the set of the current request
    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign tag   = tag_q[index];
    assign hit   = valid && tag == addr[TAG_LSB +: TAG_BITS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (selected) begin
            case (way_cmd)
                WAY_SET_DIRTY: dirty_q[cmd_index] <= 1'b1;
                WAY_ALLOC: begin
                    valid_q[cmd_index] <= 1'b1;
                    dirty_q[cmd_index] <= 1'b0;
                end
                WAY_CLEAR: begin
                    valid_q[cmd_index] <= 1'b0;
                    dirty_q[cmd_index] <= 1'b0;
                end
                WAY_CLEAR_DIRTY: dirty_q[cmd_index] <= 1'b0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (selected && way_cmd == WAY_ALLOC) begin
            tag_q[cmd_index] <= cmd_tag;
        end
    end

    // only a line the controller saw hit may turn dirty
    a_dirty_on_valid: assert property (@(posedge clk) disable iff (resetn)
        selected && way_cmd == WAY_SET_DIRTY |-> valid_q[cmd_index]);

endmodule

//--- src/dcache_way_select.sv
`timescale 1ns/100ps

module dcache_way_select (
    input  logic                                                  clk,
    input  logic                                                  resetn,
    input  logic [dcache_pkg::INDEX_BITS-1:0]                     index,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                       hit_bits,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                       valid_bits,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                       dirty_bits,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] tag_bits,
    input  logic                                                  plru_touch,
    input  logic [dcache_pkg::WAY_BITS-1:0]                       touch_way,
    output logic                                                  hit,
    output logic [dcache_pkg::WAY_BITS-1:0]                       hit_way,
    output logic [dcache_pkg::WAY_BITS-1:0]                       victim_way,
    output logic                                                  victim_dirty,
    output logic [dcache_pkg::TAG_BITS-1:0]                       victim_tag
);
    import dcache_pkg::*;

    logic [NUM_WAYS-2:0] plru_q [NUM_SETS];
    logic [NUM_WAYS-2:0] tree;
    logic [WAY_BITS-1:0] plru_way;

    assign hit = |hit_bits;

    // one-hot to way number
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hit_bits[i]) begin
                hit_way = hit_way | WAY_BITS'(i);
            end
        end
    end

    // bit 0 picks the half, bits 1 and 2 the way inside it
    assign tree     = plru_q[index];
    assign plru_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    // lowest invalid way wins over the tree
    always_comb begin
        victim_way = plru_way;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!valid_bits[i]) begin
                victim_way = WAY_BITS'(i);
            end
        end
    end

    assign victim_dirty = valid_bits[victim_way] && dirty_bits[victim_way];
    assign victim_tag   = tag_bits[victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (plru_touch) begin
            plru_q[index][0] <= !touch_way[1];
            if (touch_way[1]) begin
                plru_q[index][2] <= !touch_way[0];
            end else begin
                plru_q[index][1] <= !touch_way[0];
            end
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_bits));

endmodule

//--- verification/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              mem_valid,
    input  logic                              mem_is_write,
    input  logic [31:0]                       mem_addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic                              mem_okay,
    output logic                              mem_last,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_rdata
);
    import dcache_pkg::*;

    localparam int MEM_WORDS = 1024;

    logic [DATA_WIDTH-1:0] words [MEM_WORDS];
    logic [1:0]            beat;
    logic [9:0]            word_index;
    int                    bad_accesses;

    // offsets wrap inside the line, start word comes from the address
    assign word_index = {mem_addr[11:4], mem_addr[3:2] + beat};
    assign mem_last   = mem_okay && beat == 2'd3;
    assign mem_rdata  = words[word_index];

    // every word starts as its own word address with a marker
    initial begin
        bad_accesses = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            words[i] = 32'(i) ^ 32'h5a5a0000;
        end
    end

    // random gaps in okay, decided on the falling edge
    initial begin
        void'($urandom(32'h01d113e3));
        mem_okay = 1'b0;
        forever begin
            @(negedge clk);
            mem_okay = mem_valid && ($urandom % 4 != 0);
        end
    end

    always @(posedge clk) begin
        if (resetn) begin
            beat <= '0;
        end else if (mem_valid && mem_okay) begin
            beat <= beat + 2'd1;
            if (mem_is_write) begin
                words[word_index] <= mem_wdata;
            end
        end
    end

    always @(posedge clk) begin
        if (!resetn && mem_valid && mem_addr[31:12] != '0) begin
            bad_accesses <= bad_accesses + 1;
            $display("memory access at %h lies outside the modeled 4 KB", mem_addr);
        end
    end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT   = 200;
    localparam int MEM_BYTES = 4096;

    logic                  clk;
    logic                  resetn;
    logic                  req;
    logic [31:0]           addr;
    logic                  is_write;
    logic [DATA_BYTES-1:0] write_en;
    logic [DATA_WIDTH-1:0] wdata;
    cache_op_e             cop;
    logic                  addr_ok;
    logic                  data_ok;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  mem_valid;
    logic                  mem_is_write;
    logic [31:0]           mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic                  mem_okay;
    logic                  mem_last;
    logic [DATA_WIDTH-1:0] mem_rdata;

    logic [7:0] shadow [MEM_BYTES];
    int         checks;
    int         errors;

    dcache dcache_inst (
        .clk(clk), .resetn(resetn), .req(req), .addr(addr), .is_write(is_write),
        .write_en(write_en), .wdata(wdata), .cop(cop), .addr_ok(addr_ok), .data_ok(data_ok),
        .rdata(rdata), .mem_valid(mem_valid), .mem_is_write(mem_is_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_okay(mem_okay),
        .mem_last(mem_last), .mem_rdata(mem_rdata)
    );

    dcache_mem_model mem_model_inst (
        .clk(clk), .resetn(resetn), .mem_valid(mem_valid), .mem_is_write(mem_is_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_okay(mem_okay),
        .mem_last(mem_last), .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [DATA_WIDTH-1:0] fill_pattern(input logic [31:0] a);
        return {2'b00, a[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] shadow_word(input logic [31:0] a);
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    endfunction

    task automatic check_word(input logic [31:0] a, input logic [DATA_WIDTH-1:0] got);
        logic [DATA_WIDTH-1:0] exp;
        exp = shadow_word(a);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: read of %h gave %h, expected %h", $time, a, got, exp);
        end
    endtask

    task automatic check_mem(input logic [31:0] a, input logic [DATA_WIDTH-1:0] exp);
        logic [DATA_WIDTH-1:0] got;
        got = mem_model_inst.words[a[11:2]];
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: memory word %h holds %h, expected %h", $time, a, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // called on a falling edge, returns on the falling edge of the response
    task automatic send_request(input logic [31:0] a, input logic wr,
                                input logic [DATA_BYTES-1:0] be,
                                input logic [DATA_WIDTH-1:0] wd, input cache_op_e op,
                                output logic [DATA_WIDTH-1:0] rd);
        int waited;
        req      = 1'b1;
        addr     = a;
        is_write = wr;
        write_en = be;
        wdata    = wd;
        cop      = op;
        waited   = 0;
        #1;
        while (!addr_ok && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
            check_flag("data_ok before acceptance", data_ok, 1'b0);
        end
        if (!addr_ok) begin
            $display("timeout: request to %h was never accepted", a);
            $display("CHECKS FAILED");
            $finish;
        end else begin
            @(negedge clk);
            req = 1'b0;
            check_flag("data_ok one cycle after acceptance", data_ok, 1'b1);
            rd = rdata;
        end
    endtask

    task automatic read_word(input logic [31:0] a);
        logic [DATA_WIDTH-1:0] rd;
        send_request(a, 1'b0, '0, '0, COP_NONE, rd);
        check_word(a, rd);
    endtask

    task automatic write_word(input logic [31:0] a, input logic [DATA_BYTES-1:0] be,
                              input logic [DATA_WIDTH-1:0] wd);
        logic [DATA_WIDTH-1:0] rd;
        send_request(a, 1'b1, be, wd, COP_NONE, rd);
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (be[b]) begin
                shadow[a + b] = wd[8*b +: 8];
            end
        end
    endtask

    task automatic cache_op(input logic [31:0] a, input cache_op_e op);
        logic [DATA_WIDTH-1:0] rd;
        send_request(a, 1'b0, '0, '0, op, rd);
    endtask

    // an invalidate that never hits is only taken once the miss engine is idle
    task automatic wait_idle();
        cache_op(32'hfffffff0, COP_INV_HIT);
    endtask

    task automatic read_miss_line();
        read_word(32'h148);
        for (int k = 0; k < NUM_WORDS; k++) begin
            read_word(32'h140 + 4 * k);
        end
    endtask

    task automatic merge_strobes();
        write_word(32'h290, 4'b0101, 32'h11223344);
        write_word(32'h290, 4'b1000, 32'haabbccdd);
        write_word(32'h294, 4'b0011, 32'h01020304);
        write_word(32'h298, 4'b1110, 32'hf0e0d0c0);
        write_word(32'h29c, 4'b0000, 32'h77777777);
        for (int k = 0; k < NUM_WORDS; k++) begin
            read_word(32'h290 + 4 * k);
        end
    endtask

    // six lines of set 2 with only four ways
    task automatic fill_one_set();
        logic [31:0] a;
        for (int t = 16; t < 22; t++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                a = (t << 6) | 32'h20 | (k << 2);
                write_word(a, 4'b1111, 32'hc3000000 | a);
            end
        end
        for (int t = 16; t < 22; t++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                read_word((t << 6) | 32'h20 | (k << 2));
            end
        end
        wait_idle();
        // the tree sends every one of the six lines out once while still dirty
        for (int t = 16; t < 22; t++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                a = (t << 6) | 32'h20 | (k << 2);
                check_mem(a, shadow_word(a));
            end
        end
    endtask

    task automatic flush_index();
        for (int t = 24; t < 28; t++) begin
            write_word((t << 6) | 32'h30, 4'b1001, 32'h9a00005a | (t << 8));
            write_word((t << 6) | 32'h3c, 4'b0110, 32'h00abcd00 ^ t);
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            cache_op((w << 6) | 32'h30, COP_WB_INV_INDEX);
        end
        wait_idle();
        for (int t = 24; t < 28; t++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                check_mem((t << 6) | 32'h30 | (k << 2), shadow_word((t << 6) | 32'h30 | (k << 2)));
            end
        end
        for (int t = 24; t < 28; t++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                read_word((t << 6) | 32'h30 | (k << 2));
            end
        end
    endtask

    task automatic discard_write();
        logic [7:0] saved [DATA_BYTES];
        read_word(32'h7d4);
        for (int b = 0; b < DATA_BYTES; b++) begin
            saved[b] = shadow[32'h7d4 + b];
        end
        write_word(32'h7d4, 4'b1111, 32'h0badf00d);
        read_word(32'h7d4);
        cache_op(32'h7d4, COP_INV_HIT);
        for (int b = 0; b < DATA_BYTES; b++) begin
            shadow[32'h7d4 + b] = saved[b];
        end
        read_word(32'h7d4);
    endtask

    task automatic random_mix(input int count);
        logic [31:0] a;
        int          kind;
        for (int n = 0; n < count; n++) begin
            a    = ($urandom % 256) << 2;
            kind = $urandom % 10;
            if (kind < 4) begin
                read_word(a);
            end else if (kind < 9) begin
                write_word(a, 4'($urandom), $urandom);
            end else begin
                cache_op(a, COP_WB_INV_INDEX);
            end
        end
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] init_word;
        resetn   = 1'b1;
        req      = 1'b0;
        addr     = '0;
        is_write = 1'b0;
        write_en = '0;
        wdata    = '0;
        cop      = COP_NONE;
        checks   = 0;
        errors   = 0;
        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            init_word = fill_pattern(4 * w);
            for (int b = 0; b < DATA_BYTES; b++) begin
                shadow[4 * w + b] = init_word[8 * b +: 8];
            end
        end
        repeat (3) @(negedge clk);
        resetn = 1'b0;
        #1;
        check_flag("addr_ok after reset", addr_ok, 1'b0);
        check_flag("data_ok after reset", data_ok, 1'b0);
        check_flag("mem_valid after reset", mem_valid, 1'b0);
        @(negedge clk);

        read_miss_line();
        merge_strobes();
        fill_one_set();
        flush_index();
        discard_write();
        random_mix(150);

        // write every line back, then the whole memory must match
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                cache_op((w << 6) | (s << 4), COP_WB_INV_INDEX);
            end
        end
        wait_idle();
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            check_mem(a, shadow_word(a));
        end

        errors += mem_model_inst.bad_accesses;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
